// ==== uart_line_pkg.sv ====
// serial line widths for a fixed 8N1 frame; the bit period is baud_div plus one clock cycles

package uart_line_pkg;

    // data bits per frame, fixed by the 8N1 format
    localparam int DATA_BITS = 8;

    // width of the divisor input
    localparam int BAUD_DIV_W = 10;

    // bit index width within a frame
    localparam int BIT_IDX_W = $clog2(DATA_BITS);

    // one character on the line
    typedef logic [DATA_BITS-1:0] data_t;

    // clock cycles per bit minus one
    typedef logic [BAUD_DIV_W-1:0] baud_div_t;

    // position of a data bit, LSB first
    typedef logic [BIT_IDX_W-1:0] bit_idx_t;

endpackage

// ==== uart_state_pkg.sv ====
// FSM state encodings for the UART receiver and transmitter, both 2 bits wide

package uart_state_pkg;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

// ==== uart_rx.sv ====
// 8N1 receiver; rx_i may be asynchronous, baud_div_i must be at least 1 and stay fixed per frame
`timescale 1ns/1ps

module uart_rx import uart_line_pkg::*, uart_state_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      rx_i,
    input  baud_div_t baud_div_i,
    output data_t     byte_o,
    output logic      byte_valid_o,
    output logic      frame_err_o
);

    logic      rx_meta_r;
    logic      rx_sync_r;
    rx_state_t state_r, state_next;
    baud_div_t cnt_r, cnt_next;
    bit_idx_t  idx_r, idx_next;
    data_t     shift_r, shift_next;
    logic      valid_r, valid_next;
    logic      ferr_r, ferr_next;
    baud_div_t half_w;

    // last count of the start wait, B/2 cycles in total
    assign half_w = baud_div_t'((({1'b0, baud_div_i} + 11'd1) >> 1) - 11'd1);

    assign byte_o       = shift_r;
    assign byte_valid_o = valid_r;
    assign frame_err_o  = ferr_r;

    always_comb begin
        state_next = state_r;
        cnt_next   = cnt_r;
        idx_next   = idx_r;
        shift_next = shift_r;
        valid_next = 1'b0; // strobes last one cycle
        ferr_next  = 1'b0;

        case (state_r)
            RX_IDLE: begin
                if (!rx_sync_r) begin
                    state_next = RX_START;
                    cnt_next   = '0;
                end
            end
            RX_START: begin
                if (cnt_r == half_w) begin
                    cnt_next   = '0;
                    idx_next   = '0;
                    state_next = rx_sync_r ? RX_IDLE : RX_DATA; // high here means a glitch
                end else begin
                    cnt_next = cnt_r + 1'b1;
                end
            end
            RX_DATA: begin
                if (cnt_r == baud_div_i) begin
                    cnt_next   = '0;
                    shift_next = {rx_sync_r, shift_r[DATA_BITS-1:1]}; // lsb arrives first
                    if (idx_r == bit_idx_t'(DATA_BITS - 1)) begin
                        state_next = RX_STOP;
                    end else begin
                        idx_next = idx_r + 1'b1;
                    end
                end else begin
                    cnt_next = cnt_r + 1'b1;
                end
            end
            RX_STOP: begin
                if (cnt_r == baud_div_i) begin
                    cnt_next   = '0;
                    valid_next = rx_sync_r;
                    ferr_next  = !rx_sync_r;
                    state_next = RX_IDLE;
                end else begin
                    cnt_next = cnt_r + 1'b1;
                end
            end
            default: state_next = RX_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_meta_r <= 1'b1; // line idles high
            rx_sync_r <= 1'b1;
            state_r   <= RX_IDLE;
            cnt_r     <= '0;
            idx_r     <= '0;
            valid_r   <= 1'b0;
            ferr_r    <= 1'b0;
        end else begin
            rx_meta_r <= rx_i;
            rx_sync_r <= rx_meta_r;
            state_r   <= state_next;
            cnt_r     <= cnt_next;
            idx_r     <= idx_next;
            valid_r   <= valid_next;
            ferr_r    <= ferr_next;
        end
    end

    always_ff @(posedge clk_i) begin
        shift_r <= shift_next;
    end

endmodule

// ==== uart_tx.sv ====
// 8N1 transmitter; start_i is ignored while busy_o is high, baud_div_i must stay fixed per frame
`timescale 1ns/1ps

module uart_tx import uart_line_pkg::*, uart_state_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  baud_div_t baud_div_i,
    input  logic      start_i,
    input  data_t     data_i,
    output logic      busy_o,
    output logic      tx_o
);

    tx_state_t state_r, state_next;
    baud_div_t cnt_r, cnt_next;
    bit_idx_t  idx_r, idx_next;
    data_t     shift_r, shift_next;
    logic      tx_r, tx_next;

    assign busy_o = (state_r != TX_IDLE); // high for exactly ten bit periods
    assign tx_o   = tx_r;

    always_comb begin
        state_next = state_r;
        cnt_next   = cnt_r;
        idx_next   = idx_r;
        shift_next = shift_r;
        tx_next    = tx_r;

        case (state_r)
            TX_IDLE: begin
                if (start_i) begin
                    state_next = TX_START;
                    cnt_next   = '0;
                    shift_next = data_i;
                    tx_next    = 1'b0; // start bit
                end
            end
            TX_START: begin
                if (cnt_r == baud_div_i) begin
                    cnt_next   = '0;
                    idx_next   = '0;
                    tx_next    = shift_r[0];
                    shift_next = shift_r >> 1;
                    state_next = TX_DATA;
                end else begin
                    cnt_next = cnt_r + 1'b1;
                end
            end
            TX_DATA: begin
                if (cnt_r == baud_div_i) begin
                    cnt_next = '0;
                    if (idx_r == bit_idx_t'(DATA_BITS - 1)) begin
                        tx_next    = 1'b1; // stop bit
                        state_next = TX_STOP;
                    end else begin
                        idx_next   = idx_r + 1'b1;
                        tx_next    = shift_r[0];
                        shift_next = shift_r >> 1;
                    end
                end else begin
                    cnt_next = cnt_r + 1'b1;
                end
            end
            TX_STOP: begin
                if (cnt_r == baud_div_i) begin
                    cnt_next   = '0;
                    state_next = TX_IDLE;
                end else begin
                    cnt_next = cnt_r + 1'b1;
                end
            end
            default: state_next = TX_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_r <= TX_IDLE;
            cnt_r   <= '0;
            idx_r   <= '0;
            tx_r    <= 1'b1;
        end else begin
            state_r <= state_next;
            cnt_r   <= cnt_next;
            idx_r   <= idx_next;
            tx_r    <= tx_next;
        end
    end

    always_ff @(posedge clk_i) begin
        shift_r <= shift_next;
    end

endmodule

// ==== uart_rx_fifo.sv ====
// first-word-through byte FIFO; FIFO_DEPTH must be a power of two, full writes are dropped
`timescale 1ns/1ps

module uart_rx_fifo import uart_line_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  wr_i,
    input  data_t wr_data_i,
    input  logic  rd_i,
    output data_t rd_data_o,
    output logic  empty_o,
    output logic  full_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    data_t            mem_r [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_r;
    logic [PTR_W-1:0] rd_ptr_r;
    logic [CNT_W-1:0] count_r;
    logic             wr_ok;
    logic             rd_ok;

    assign empty_o   = (count_r == '0);
    assign full_o    = (count_r == CNT_W'(FIFO_DEPTH));
    assign rd_data_o = mem_r[rd_ptr_r]; // head entry, always visible

    assign wr_ok = wr_i && !full_o;
    assign rd_ok = rd_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (wr_ok) begin
            mem_r[wr_ptr_r] <= wr_data_i;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r; // both or neither
            endcase
        end
    end

endmodule

// ==== uart_core.sv ====
// UART top with one shared divisor for both directions; 8N1 only, no flow control
`timescale 1ns/1ps

module uart_core import uart_line_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic      clk_i,
    input  logic      rst_i,
    input  baud_div_t baud_div_i,
    input  logic      tx_start_i,
    input  data_t     tx_data_i,
    output logic      tx_busy_o,
    output logic      tx_o,
    input  logic      rx_i,
    input  logic      rx_rd_i,
    output data_t     rx_data_o,
    output logic      rx_empty_o,
    output logic      rx_full_o,
    output logic      rx_frame_err_o
);

    data_t rx_byte;
    logic  rx_byte_valid;

    uart_tx i_uart_tx (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .baud_div_i (baud_div_i),
        .start_i    (tx_start_i),
        .data_i     (tx_data_i),
        .busy_o     (tx_busy_o),
        .tx_o       (tx_o)
    );

    uart_rx i_uart_rx (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .rx_i         (rx_i),
        .baud_div_i   (baud_div_i),
        .byte_o       (rx_byte),
        .byte_valid_o (rx_byte_valid),
        .frame_err_o  (rx_frame_err_o)
    );

    // received bytes wait here until the host reads them
    uart_rx_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_uart_rx_fifo (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_i      (rx_byte_valid),
        .wr_data_i (rx_byte),
        .rd_i      (rx_rd_i),
        .rd_data_o (rx_data_o),
        .empty_o   (rx_empty_o),
        .full_o    (rx_full_o)
    );

endmodule

// ==== tb_uart_core.sv ====
// runs at B = 16 cycles with baud_div_i tied to 15; the run stops at the first mismatch
`timescale 1ns/1ps

module tb_uart_core import uart_line_pkg::*; ();

    localparam baud_div_t BAUD_DIV   = 10'd15;
    localparam int        BIT_CYC    = BAUD_DIV + 1;
    localparam int        FIFO_DEPTH = 4;
    // limit is three times the 4000 or so cycles of 25 frames at 10*B
    localparam int        TIMEOUT_CYC = 12000;

    logic   clk_i;
    logic   rst_i;
    logic   tx_start_i;
    data_t  tx_data_i;
    logic   tx_busy_o;
    logic   tx_o;
    logic   rx_line;
    logic   rx_rd_i;
    data_t  rx_data_o;
    logic   rx_empty_o;
    logic   rx_full_o;
    logic   rx_frame_err_o;
    logic   loop_sel;      // high when rx_i follows tx_o
    logic   rx_bb;         // bit-banged line
    logic   read_en;
    int     ferr_cnt  = 0;
    int     cycle_cnt = 0;
    integer seed;
    data_t  exp_q[$];

    assign rx_line = loop_sel ? tx_o : rx_bb;

    uart_core #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_uart_core (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .baud_div_i     (BAUD_DIV),
        .tx_start_i     (tx_start_i),
        .tx_data_i      (tx_data_i),
        .tx_busy_o      (tx_busy_o),
        .tx_o           (tx_o),
        .rx_i           (rx_line),
        .rx_rd_i        (rx_rd_i),
        .rx_data_o      (rx_data_o),
        .rx_empty_o     (rx_empty_o),
        .rx_full_o      (rx_full_o),
        .rx_frame_err_o (rx_frame_err_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (!rst_i && rx_frame_err_o) ferr_cnt++;
        if (cycle_cnt == TIMEOUT_CYC) begin
            $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYC);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR @%0t: %s got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // returns {written, byte} for a frame decoded the way the line carries it
    function automatic logic [DATA_BITS:0] ref_rx(input data_t sent, input logic stop_bit);
        logic [DATA_BITS+1:0] frame;
        frame = {stop_bit, sent, 1'b0};
        return {frame[DATA_BITS+1], frame[DATA_BITS:1]};
    endfunction

    task automatic push_expected(input data_t sent, input logic stop_bit);
        logic [DATA_BITS:0] r;
        r = ref_rx(sent, stop_bit);
        if (r[DATA_BITS]) exp_q.push_back(r[DATA_BITS-1:0]);
    endtask

    task automatic step(input int n);
        repeat (n) @(posedge clk_i);
        #1;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) step(1);
        step(2);
    endtask

    // checks every bit at mid period and pulses start once while busy if poke is set
    task automatic send_tx_frame(input data_t b, input logic poke);
        logic [9:0] frame;
        int         n;
        frame      = {1'b1, b, 1'b0};
        tx_data_i  = b;
        tx_start_i = 1'b1;
        step(1); // strobe taken here
        tx_data_i = ~b;
        for (n = 0; n < 10 * BIT_CYC; n++) begin
            tx_start_i = poke && (n == 4 * BIT_CYC);
            check_flag(tx_busy_o, 1'b1, "tx busy during frame");
            if (n % BIT_CYC == BIT_CYC / 2) check_flag(tx_o, frame[n / BIT_CYC], "tx bit");
            step(1);
        end
        check_flag(tx_busy_o, 1'b0, "tx busy after ten bit periods");
    endtask

    task automatic bang_frame(input data_t b, input logic stop_bit);
        logic [9:0] frame;
        int         k;
        frame = {stop_bit, b, 1'b0};
        for (k = 0; k < 10; k++) begin
            rx_bb = frame[k];
            step(BIT_CYC);
        end
        rx_bb = 1'b1;
    endtask

    initial begin : fifo_reader
        rx_rd_i = 1'b0;
        forever begin
            step(1);
            rx_rd_i = 1'b0;
            if (read_en && !rx_empty_o) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected byte %h in the receive FIFO at %0t", rx_data_o, $time);
                    abort_run();
                end else begin
                    check_byte(rx_data_o, exp_q.pop_front(), "received byte");
                    rx_rd_i = 1'b1;
                end
            end
        end
    end

    initial begin
        data_t b;
        int    i;
        seed       = 32'h362a;
        rst_i      = 1'b1;
        tx_start_i = 1'b0;
        tx_data_i  = '0;
        loop_sel   = 1'b0;
        rx_bb      = 1'b1;
        read_en    = 1'b0;
        step(4);
        rst_i = 1'b0;
        check_flag(tx_o, 1'b1, "tx line idle");
        check_flag(tx_busy_o, 1'b0, "tx busy after reset");
        check_flag(rx_empty_o, 1'b1, "fifo empty after reset");
        check_flag(rx_full_o, 1'b0, "fifo full after reset");
        check_flag(rx_frame_err_o, 1'b0, "frame error after reset");
        // framing with the receive line held idle
        send_tx_frame(8'h55, 1'b0);
        send_tx_frame(8'ha3, 1'b1);
        for (i = 0; i < 4; i++) send_tx_frame(data_t'($random(seed)), 1'b0);
        check_flag(rx_empty_o, 1'b1, "nothing received during framing");
        loop_sel = 1'b1;
        read_en  = 1'b1;
        for (i = 0; i < 12; i++) begin
            b = data_t'($random(seed));
            push_expected(b, 1'b1);
            send_tx_frame(b, 1'b0);
        end
        wait_drain();
        check_flag(ferr_cnt == 0, 1'b1, "no frame error in loopback");
        // broken stop bit and then a short glitch
        loop_sel = 1'b0;
        read_en  = 1'b0;
        b = data_t'($random(seed));
        push_expected(b, 1'b0);
        bang_frame(b, 1'b0);
        step(2 * BIT_CYC);
        check_flag(ferr_cnt == 1, 1'b1, "single frame error pulse");
        check_flag(rx_empty_o, 1'b1, "bad frame dropped");
        rx_bb = 1'b0;
        step(BIT_CYC / 4);
        rx_bb = 1'b1;
        step(12 * BIT_CYC); // long enough for a falsely started frame to land
        check_flag(ferr_cnt == 1, 1'b1, "no frame error from glitch");
        check_flag(rx_empty_o, 1'b1, "no byte from glitch");
        loop_sel = 1'b1;
        for (i = 0; i < FIFO_DEPTH + 2; i++) begin
            b = data_t'($random(seed));
            if (i < FIFO_DEPTH) push_expected(b, 1'b1); // the rest meet a full FIFO
            send_tx_frame(b, 1'b0);
            check_flag(rx_full_o, i >= FIFO_DEPTH - 1, "fifo full flag");
        end
        read_en = 1'b1;
        wait_drain();
        check_flag(rx_empty_o, 1'b1, "fifo empty after draining");
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
uart_line_pkg.sv
uart_state_pkg.sv
uart_rx.sv
uart_tx.sv
uart_rx_fifo.sv
uart_core.sv
tb_uart_core.sv
